// File: bench/pad_dma_assertions.sv
// AXI handshake checks on the padding DMA FSM
// Bound into pad_dma_ctrl at the bottom of this file
`timescale 1ns/1ps

module pad_dma_assertions (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               arvalid_i,
    input logic                               arready_i,
    input logic                               awvalid_i,
    input logic                               awready_i,
    input logic                               wvalid_i,
    input logic                               wready_i,
    input logic                               wlast_i,
    input logic                               bvalid_i,
    input logic                               bready_i,
    input logic [1:0]                         read_row_i,
    input logic [pad_dma_pkg::TILE_IDX_W-1:0] wr_row_i,
    input logic [pad_dma_pkg::TILE_IDX_W-1:0] wr_col_i
);
    int fail_count = 0;   // Failed assertions so far

    // Row and column select the address and data on each channel
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(read_row_i))
        else begin $error("AR request changed before arready"); fail_count++; end
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(wr_row_i))
        else begin $error("AW request changed before awready"); fail_count++; end
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wr_col_i))
        else begin $error("W beat changed before wready"); fail_count++; end
    b_after_w: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && wready_i && wlast_i |=> bready_i)
        else begin $error("bready missing after the last W beat"); fail_count++; end
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bready_i && !bvalid_i |=> bready_i)
        else begin $error("bready dropped before the B handshake"); fail_count++; end
    no_aw_in_b: assert property (@(posedge clk) disable iff (!rst_n)
        bready_i |-> !awvalid_i)
        else begin $error("AW issued while a B is pending"); fail_count++; end
    wlast_wvalid: assert property (@(posedge clk) disable iff (!rst_n)
        wlast_i |-> wvalid_i)
        else begin $error("wlast without wvalid"); fail_count++; end

endmodule

bind pad_dma_ctrl pad_dma_assertions u_assert (
    .clk, .rst_n,
    .arvalid_i(arvalid_o), .arready_i, .awvalid_i(awvalid_o), .awready_i,
    .wvalid_i(wvalid_o), .wready_i, .wlast_i(wlast_o), .bvalid_i, .bready_i(bready_o),
    .read_row_i(read_row_o), .wr_row_i(wr_row_o), .wr_col_i(wr_col_o)
);

// File: bench/pad_dma_tb.sv
// Testbench of the mirror-padding DMA engine
// Directed runs against an AXI memory model, every padded word checked
// against the reflection rule
`timescale 1ns/1ps

module pad_dma_tb;
    import pad_dma_pkg::*;

    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int MEM_WORDS    = 4096;
    localparam int BLOCK_CYCLES = 400;               // Worst case per block with stalls
    localparam int TOTAL_BLOCKS = 1 + 4 + 9 + 4 + 1;
    // One more block time for the zero-width wait
    localparam int WATCHDOG     = 16 + (TOTAL_BLOCKS + 1) * BLOCK_CYCLES + 500;

    logic clk = 1'b0, rst_n, start, done, stall_en;
    logic [ADDR_W-1:0]      src_addr, dst_addr, araddr, awaddr;
    logic [MAT_W_W-1:0]     mat_width;
    logic [BURST_LEN_W-1:0] arlen, awlen;
    logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic wlast, wvalid, wready, bvalid, bready;
    logic [DATA_W-1:0]      rdata, wdata;
    logic [DATA_W-1:0]      src_img [0:3599];   // Source matrix as written
    logic [DATA_W-1:0]      saved [$];
    logic [BURST_LEN_W-1:0] exp_awlen [$];      // awlen of each write burst still to come
    integer                 seed = 32;

    always #50 clk = ~clk;

    pad_dma_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_dut (
        .clk, .rst_n, .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(mat_width),
        .start_i(start), .done_o(done), .araddr_o(araddr), .arlen_o(arlen),
        .arvalid_o(arvalid), .arready_i(arready), .rdata_i(rdata), .rlast_i(rlast),
        .rvalid_i(rvalid), .rready_o(rready), .awaddr_o(awaddr), .awlen_o(awlen),
        .awvalid_o(awvalid), .awready_i(awready), .wdata_o(wdata), .wlast_o(wlast),
        .wvalid_o(wvalid), .wready_i(wready), .bvalid_i(bvalid), .bready_o(bready)
    );

    pad_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem (
        .clk, .rst_n, .stall_i(stall_en), .araddr_i(araddr), .arlen_i(arlen),
        .arvalid_i(arvalid), .arready_o(arready), .rdata_o(rdata), .rlast_o(rlast),
        .rvalid_o(rvalid), .rready_i(rready), .awaddr_i(awaddr), .awvalid_i(awvalid),
        .awready_o(awready), .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid),
        .wready_o(wready), .bvalid_o(bvalid), .bready_i(bready)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input logic [BURST_LEN_W-1:0] got, exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    function automatic logic [DATA_W-1:0] background_word(input int i);
        return 32'hbad0_0000 ^ (i * 32'h0001_0001);
    endfunction

    // Reflection about the first and last source row or column
    function automatic int mirror_idx(input int k, input int w);
        if (k < 0) return 1;
        if (k == w) return w - 2;
        return k;
    endfunction

    // One write burst per tile row, border rows and columns only on matrix edges
    task automatic expect_bursts(input int w);
        int n, rows, len;
        n = w / BLOCK_DIM;
        exp_awlen = {};
        for (int by = 0; by < n; by++) begin
            for (int bx = 0; bx < n; bx++) begin
                rows = BLOCK_DIM + (by == 0) + (by == n - 1);
                len  = BLOCK_DIM - 1 + (bx == 0) + (bx == n - 1);
                repeat (rows)
                    exp_awlen.push_back(BURST_LEN_W'(len));
            end
        end
    endtask

    // Each AW handshake takes the next expected burst length
    always @(negedge clk) begin
        if (awvalid && awready) begin
            if (exp_awlen.size() == 0)
                report_failure("AW burst issued when none was expected");
            else
                check_len("awlen_o", awlen, exp_awlen.pop_front());
        end
    end

    task automatic fill_background();
        for (int i = 0; i < MEM_WORDS; i++) u_mem.mem[i] = background_word(i);
    endtask

    task automatic fill_source(input int base, input int w, input bit rnd, input int tag);
        for (int i = 0; i < w * w; i++) begin
            src_img[i] = rnd ? $random(seed) : {8'(tag), 8'h00, 16'(i)};
            u_mem.mem[base + i] = src_img[i];
        end
    endtask

    task automatic check_padded(input int dst, input int w, input string tag);
        logic [DATA_W-1:0] exp;
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                exp = src_img[mirror_idx(r - 1, w) * w + mirror_idx(c - 1, w)];
                check_word($sformatf("%s[%0d][%0d]", tag, r, c),
                           u_mem.mem[dst + r * (w + 2) + c], exp);
            end
        end
    endtask

    task automatic check_guard(input int dst, input int w);
        int last;
        last = dst + (w + 2) * (w + 2) - 1;
        for (int k = 1; k <= 4; k++) begin
            check_word($sformatf("mem[%0d]", dst - k), u_mem.mem[dst - k],
                       background_word(dst - k));
            check_word($sformatf("mem[%0d]", last + k), u_mem.mem[last + k],
                       background_word(last + k));
        end
    endtask

    task automatic run_dma(input int src, input int dst, input int w);
        int cycles;
        @(negedge clk);
        expect_bursts(w);
        src_addr  = ADDR_W'(src * WORD_BYTES);
        dst_addr  = ADDR_W'(dst * WORD_BYTES);
        mat_width = MAT_W_W'(w);
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_level("done_o", done, 1'b0);
        check_level("arvalid_o", arvalid, 1'b1);
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > (w / 4) * (w / 4) * BLOCK_CYCLES + 100)
                report_failure("Timed out waiting for done_o to rise");
        end
        if (exp_awlen.size() != 0)
            report_failure("Run ended with write bursts still missing");
    endtask

    task automatic test_reset_state();
        check_level("done_o", done, 1'b1);
        check_level("arvalid_o", arvalid, 1'b0);
        check_level("awvalid_o", awvalid, 1'b0);
        check_level("wvalid_o", wvalid, 1'b0);
        check_level("rready_o", rready, 1'b0);
        check_level("bready_o", bready, 1'b0);
    endtask

    task automatic test_padded_run(input int src, input int dst, input int w, input bit rnd);
        fill_background();
        fill_source(src, w, rnd, w);
        run_dma(src, dst, w);
        check_padded(dst, w, "dst");
        check_guard(dst, w);
    endtask

    task automatic test_zero_width();
        fill_background();
        @(negedge clk);
        dst_addr  = ADDR_W'(2560 * WORD_BYTES);
        mat_width = '0;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (BLOCK_CYCLES) begin        // Window covers a whole block run
            check_level("done_o", done, 1'b1);
            check_level("arvalid_o", arvalid, 1'b0);
            @(negedge clk);
        end
        for (int i = 2560; i < 2560 + 36; i++)
            check_word($sformatf("mem[%0d]", i), u_mem.mem[i], background_word(i));
    endtask

    task automatic test_back_to_back();
        fill_background();
        fill_source(64, 8, 1'b0, 8'h33);
        run_dma(64, 1536, 8);
        check_padded(1536, 8, "dst_a");
        saved = {};
        for (int i = 0; i < 100; i++) saved.push_back(u_mem.mem[1536 + i]);
        fill_source(128, 4, 1'b0, 8'h44);
        run_dma(128, 1792, 4);                   // Started right after done
        check_padded(1792, 4, "dst_b");
        foreach (saved[i]) check_word("dst_a", u_mem.mem[1536 + i], saved[i]);
        check_guard(1536, 8);
        check_guard(1792, 4);
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        stall_en  = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        mat_width = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_padded_run(0, 1024, 4, 1'b0);
        stall_en = 1'b1;
        test_padded_run(256, 2048, 8, 1'b0);
        stall_en = 1'b0;
        test_padded_run(512, 3072, 12, 1'b1);
        test_zero_width();
        stall_en = 1'b1;
        test_back_to_back();
        if (u_dut.u_ctrl.u_assert.fail_count != 0) begin
            report_failure("Protocol assertions failed during the run");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: bench/pad_mem_model.sv
// AXI slave memory for the padding DMA testbench
// Serves one read burst and one write burst at a time from a word array;
// with stall_i high each ready is dropped at random
`timescale 1ns/1ps

module pad_mem_model #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32,
    parameter int IDX_W  = 12
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                stall_i,
    input  logic [ADDR_W-1:0]                   araddr_i,
    input  logic [pad_dma_pkg::BURST_LEN_W-1:0] arlen_i,
    input  logic                                arvalid_i,
    output logic                                arready_o,
    output logic [DATA_W-1:0]                   rdata_o,
    output logic                                rlast_o,
    output logic                                rvalid_o,
    input  logic                                rready_i,
    input  logic [ADDR_W-1:0]                   awaddr_i,
    input  logic                                awvalid_i,
    output logic                                awready_o,
    input  logic [DATA_W-1:0]                   wdata_i,
    input  logic                                wlast_i,
    input  logic                                wvalid_i,
    output logic                                wready_o,
    output logic                                bvalid_o,
    input  logic                                bready_i
);
    import pad_dma_pkg::*;

    logic [DATA_W-1:0]      mem [0:(1 << IDX_W)-1];   // Word addressed
    logic [IDX_W-1:0]       rd_idx, wr_idx;
    logic [BURST_LEN_W-1:0] rd_beat, rd_len;
    logic                   rd_busy, b_pend;
    integer                 seed = 32;

    assign rvalid_o = rd_busy;
    assign rdata_o  = mem[rd_idx];
    assign rlast_o  = rd_busy & (rd_beat == rd_len);
    assign bvalid_o = b_pend;

    always @(posedge clk) begin
        if (!rst_n) begin
            rd_busy   <= 1'b0;
            b_pend    <= 1'b0;
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
        end else begin
            // Ready about three cycles in four while stalling
            arready_o <= !stall_i || (($random(seed) & 3) != 0);
            awready_o <= !stall_i || (($random(seed) & 3) != 0);
            wready_o  <= !stall_i || (($random(seed) & 3) != 0);
            if (arvalid_i && arready_o) begin
                rd_idx  <= araddr_i[IDX_W+1:2];
                rd_len  <= arlen_i;
                rd_beat <= '0;
                rd_busy <= 1'b1;
            end
            if (rvalid_o && rready_i) begin
                rd_idx  <= rd_idx + 1'b1;
                rd_beat <= rd_beat + 1'b1;
                if (rlast_o)
                    rd_busy <= 1'b0;
            end
            if (awvalid_i && awready_o)
                wr_idx <= awaddr_i[IDX_W+1:2];
            if (wvalid_i && wready_o) begin
                mem[wr_idx] <= wdata_i;
                wr_idx      <= wr_idx + 1'b1;
                if (wlast_i)
                    b_pend <= 1'b1;              // Response after the last beat
            end
            if (bvalid_o && bready_i)
                b_pend <= 1'b0;
        end
    end

endmodule

// File: common/pad_dma_pkg.sv
// Shared constants of the padding DMA engine
// Block and tile geometry plus the fixed AXI burst settings
package pad_dma_pkg;

    // Source block edge, also bursts per block and beats per read burst
    localparam int BLOCK_DIM  = 4;
    localparam int TILE_DIM   = 6;    // Block plus one border cell per side
    localparam int TILE_IDX_W = 3;

    localparam int WORD_BYTES = 4;

    // AXI len field, fixed 4-beat reads
    localparam int                     BURST_LEN_W  = 4;
    localparam logic [BURST_LEN_W-1:0] RD_BURST_LEN = 4'd3;

    localparam int MAT_W_W   = 6;     // Matrix width up to 60
    localparam int BLK_IDX_W = 4;     // Up to 15 blocks per side

endpackage

// File: files.f
common/pad_dma_pkg.sv
hw/block_walker.sv
hw/pad_addr_gen.sv
tile/pad_tile_buffer.sv
hw/pad_dma_ctrl.sv
hw/pad_dma_top.sv
bench/pad_mem_model.sv
bench/pad_dma_assertions.sv
bench/pad_dma_tb.sv

// File: hw/block_walker.sv
// Walks the 4x4 blocks of the source matrix in row-major order
// and flags which matrix edges the current block touches
`timescale 1ns/1ps

module block_walker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load_i,
    input  logic                               advance_i,
    input  logic [pad_dma_pkg::MAT_W_W-1:0]    mat_width_i,
    output logic [pad_dma_pkg::BLK_IDX_W-1:0]  block_x_o,
    output logic [pad_dma_pkg::BLK_IDX_W-1:0]  block_y_o,
    output logic                               edge_top_o,
    output logic                               edge_bottom_o,
    output logic                               edge_left_o,
    output logic                               edge_right_o,
    output logic                               last_block_o
);
    import pad_dma_pkg::*;

    logic [BLK_IDX_W-1:0] blocks_per_side;
    logic [BLK_IDX_W-1:0] last_idx;

    assign last_idx = blocks_per_side - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blocks_per_side <= '0;
            block_x_o       <= '0;
            block_y_o       <= '0;
        end else if (load_i) begin
            blocks_per_side <= BLK_IDX_W'(mat_width_i / BLOCK_DIM);
            block_x_o       <= '0;
            block_y_o       <= '0;
        end else if (advance_i) begin
            if (block_x_o == last_idx) begin      // Wrap to the next block row
                block_x_o <= '0;
                block_y_o <= block_y_o + 1'b1;
            end else begin
                block_x_o <= block_x_o + 1'b1;
            end
        end
    end

    assign edge_top_o    = (block_y_o == '0);
    assign edge_bottom_o = (block_y_o == last_idx);
    assign edge_left_o   = (block_x_o == '0);
    assign edge_right_o  = (block_x_o == last_idx);
    assign last_block_o  = edge_bottom_o & edge_right_o;

endmodule

// File: hw/pad_addr_gen.sv
// Address generator for the padding DMA
// Holds the run configuration and derives the read address, the write
// address and the tile region that the current block writes
`timescale 1ns/1ps

module pad_addr_gen #(
    parameter int ADDR_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load_i,
    input  logic [ADDR_W-1:0]                    src_addr_i,
    input  logic [ADDR_W-1:0]                    dst_addr_i,
    input  logic [pad_dma_pkg::MAT_W_W-1:0]      mat_width_i,
    input  logic [pad_dma_pkg::BLK_IDX_W-1:0]    block_x_i,
    input  logic [pad_dma_pkg::BLK_IDX_W-1:0]    block_y_i,
    input  logic                                 edge_top_i,
    input  logic                                 edge_bottom_i,
    input  logic                                 edge_left_i,
    input  logic                                 edge_right_i,
    input  logic [1:0]                           read_row_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]   wr_row_i,
    output logic [ADDR_W-1:0]                    araddr_o,
    output logic [ADDR_W-1:0]                    awaddr_o,
    output logic [pad_dma_pkg::BURST_LEN_W-1:0]  awlen_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]   first_row_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]   last_row_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]   first_col_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]   last_col_o
);
    import pad_dma_pkg::*;

    logic [ADDR_W-1:0]  src_base, dst_base;
    logic [MAT_W_W-1:0] width;
    logic [ADDR_W-1:0]  rd_line, rd_word, wr_line, wr_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_base <= '0;
            dst_base <= '0;
            width    <= '0;
        end else if (load_i) begin
            src_base <= src_addr_i;
            dst_base <= dst_addr_i;
            width    <= mat_width_i;
        end
    end

    // Border rows and columns only on the matrix edges
    assign first_row_o = edge_top_i    ? '0 : TILE_IDX_W'(1);
    assign last_row_o  = edge_bottom_i ? TILE_IDX_W'(TILE_DIM - 1) : TILE_IDX_W'(BLOCK_DIM);
    assign first_col_o = edge_left_i   ? '0 : TILE_IDX_W'(1);
    assign last_col_o  = edge_right_i  ? TILE_IDX_W'(TILE_DIM - 1) : TILE_IDX_W'(BLOCK_DIM);

    // Source word index, W words per row
    assign rd_line  = ADDR_W'(block_y_i) * BLOCK_DIM + ADDR_W'(read_row_i);
    assign rd_word  = rd_line * ADDR_W'(width) + ADDR_W'(block_x_i) * BLOCK_DIM;
    assign araddr_o = src_base + rd_word * WORD_BYTES;

    // Tile row 0 is padded row 4*by, padded rows are W+2 words
    assign wr_line  = ADDR_W'(block_y_i) * BLOCK_DIM + ADDR_W'(wr_row_i);
    assign wr_word  = wr_line * (ADDR_W'(width) + 2'd2)
                      + ADDR_W'(block_x_i) * BLOCK_DIM + ADDR_W'(first_col_o);
    assign awaddr_o = dst_base + wr_word * WORD_BYTES;
    assign awlen_o  = BURST_LEN_W'(last_col_o - first_col_o);

endmodule

// File: hw/pad_dma_ctrl.sv
// Engine FSM of the padding DMA
// Reads a block as four row bursts, triggers padding, then writes the
// tile region one AXI burst per row and waits for B after each
`timescale 1ns/1ps

module pad_dma_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_i,
    input  logic [pad_dma_pkg::MAT_W_W-1:0]     mat_width_i,
    output logic                                done_o,
    output logic                                arvalid_o,
    input  logic                                arready_i,
    input  logic                                rlast_i,
    input  logic                                rvalid_i,
    output logic                                rready_o,
    output logic                                awvalid_o,
    input  logic                                awready_i,
    output logic                                wlast_o,
    output logic                                wvalid_o,
    input  logic                                wready_i,
    input  logic                                bvalid_i,
    output logic                                bready_o,
    output logic                                load_o,
    output logic                                advance_o,
    output logic                                store_o,
    output logic                                pad_o,
    output logic [1:0]                          read_row_o,
    output logic [1:0]                          read_col_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]  wr_row_o,
    output logic [pad_dma_pkg::TILE_IDX_W-1:0]  wr_col_o,
    input  logic                                last_block_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  first_row_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  last_row_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  first_col_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  last_col_i
);
    import pad_dma_pkg::*;

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_RREQ  = 3'd1;
    localparam logic [2:0] S_RDATA = 3'd2;
    localparam logic [2:0] S_PAD   = 3'd3;
    localparam logic [2:0] S_WREQ  = 3'd4;
    localparam logic [2:0] S_WDATA = 3'd5;
    localparam logic [2:0] S_WRESP = 3'd6;

    logic [2:0] state;
    logic       r_hs, w_hs, tile_done;

    assign r_hs      = rvalid_i & rready_o;
    assign w_hs      = wvalid_o & wready_i;
    assign tile_done = (wr_row_o == last_row_i);   // Current row is the last one

    assign done_o    = (state == S_IDLE);
    assign load_o    = done_o & start_i & (mat_width_i != '0);
    assign arvalid_o = (state == S_RREQ);
    assign rready_o  = (state == S_RDATA);
    assign store_o   = r_hs;
    assign pad_o     = (state == S_PAD);
    assign awvalid_o = (state == S_WREQ);
    assign wvalid_o  = (state == S_WDATA);
    assign wlast_o   = wvalid_o & (wr_col_o == last_col_i);
    assign bready_o  = (state == S_WRESP);
    assign advance_o = bready_o & bvalid_i & tile_done & ~last_block_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            read_row_o <= '0;
            read_col_o <= '0;
            wr_row_o   <= '0;
            wr_col_o   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (load_o) begin
                        read_row_o <= '0;
                        read_col_o <= '0;
                        state      <= S_RREQ;
                    end
                end
                S_RREQ: if (arready_i) state <= S_RDATA;
                S_RDATA: begin
                    if (r_hs) begin
                        read_col_o <= read_col_o + 1'b1;
                        if (rlast_i) begin
                            read_col_o <= '0;
                            if (read_row_o == 2'(BLOCK_DIM - 1)) begin
                                read_row_o <= '0;
                                state      <= S_PAD;
                            end else begin
                                read_row_o <= read_row_o + 1'b1;
                                state      <= S_RREQ;
                            end
                        end
                    end
                end
                S_PAD: begin                // Region limits are stable by now
                    wr_row_o <= first_row_i;
                    wr_col_o <= first_col_i;
                    state    <= S_WREQ;
                end
                S_WREQ: if (awready_i) state <= S_WDATA;
                S_WDATA: begin
                    if (w_hs) begin
                        if (wlast_o)
                            state <= S_WRESP;
                        else
                            wr_col_o <= wr_col_o + 1'b1;
                    end
                end
                S_WRESP: begin
                    if (bvalid_i) begin
                        wr_col_o <= first_col_i;
                        if (!tile_done) begin
                            wr_row_o <= wr_row_o + 1'b1;
                            state    <= S_WREQ;
                        end else if (last_block_i) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_RREQ;   // Walker steps on this edge
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hw/pad_dma_top.sv
// Top level of the mirror-padding DMA engine
// Connects the FSM to the block walker, address generator and tile buffer
`timescale 1ns/1ps

module pad_dma_top #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [ADDR_W-1:0]                    src_addr_i,
    input  logic [ADDR_W-1:0]                    dst_addr_i,
    input  logic [pad_dma_pkg::MAT_W_W-1:0]      mat_width_i,
    input  logic                                 start_i,
    output logic                                 done_o,
    output logic [ADDR_W-1:0]                    araddr_o,
    output logic [pad_dma_pkg::BURST_LEN_W-1:0]  arlen_o,
    output logic                                 arvalid_o,
    input  logic                                 arready_i,
    input  logic [DATA_W-1:0]                    rdata_i,
    input  logic                                 rlast_i,
    input  logic                                 rvalid_i,
    output logic                                 rready_o,
    output logic [ADDR_W-1:0]                    awaddr_o,
    output logic [pad_dma_pkg::BURST_LEN_W-1:0]  awlen_o,
    output logic                                 awvalid_o,
    input  logic                                 awready_i,
    output logic [DATA_W-1:0]                    wdata_o,
    output logic                                 wlast_o,
    output logic                                 wvalid_o,
    input  logic                                 wready_i,
    input  logic                                 bvalid_i,
    output logic                                 bready_o
);
    import pad_dma_pkg::*;

    logic                  load, advance, store, pad, last_block;
    logic [1:0]            read_row, read_col;
    logic [TILE_IDX_W-1:0] wr_row, wr_col;
    logic [TILE_IDX_W-1:0] first_row, last_row, first_col, last_col;
    logic [BLK_IDX_W-1:0]  block_x, block_y;
    logic                  edge_top, edge_bottom, edge_left, edge_right;

    assign arlen_o = RD_BURST_LEN;    // Every read is one block row

    pad_dma_ctrl u_ctrl (
        .clk, .rst_n, .start_i, .mat_width_i, .done_o,
        .arvalid_o, .arready_i, .rlast_i, .rvalid_i, .rready_o,
        .awvalid_o, .awready_i, .wlast_o, .wvalid_o, .wready_i,
        .bvalid_i, .bready_o,
        .load_o(load), .advance_o(advance), .store_o(store), .pad_o(pad),
        .read_row_o(read_row), .read_col_o(read_col),
        .wr_row_o(wr_row), .wr_col_o(wr_col),
        .last_block_i(last_block),
        .first_row_i(first_row), .last_row_i(last_row),
        .first_col_i(first_col), .last_col_i(last_col)
    );

    block_walker u_walker (
        .clk, .rst_n, .load_i(load), .advance_i(advance), .mat_width_i,
        .block_x_o(block_x), .block_y_o(block_y),
        .edge_top_o(edge_top), .edge_bottom_o(edge_bottom),
        .edge_left_o(edge_left), .edge_right_o(edge_right),
        .last_block_o(last_block)
    );

    pad_addr_gen #(.ADDR_W(ADDR_W)) u_addr (
        .clk, .rst_n, .load_i(load), .src_addr_i, .dst_addr_i, .mat_width_i,
        .block_x_i(block_x), .block_y_i(block_y),
        .edge_top_i(edge_top), .edge_bottom_i(edge_bottom),
        .edge_left_i(edge_left), .edge_right_i(edge_right),
        .read_row_i(read_row), .wr_row_i(wr_row),
        .araddr_o, .awaddr_o, .awlen_o,
        .first_row_o(first_row), .last_row_o(last_row),
        .first_col_o(first_col), .last_col_o(last_col)
    );

    pad_tile_buffer #(.DATA_W(DATA_W)) u_tile (
        .clk, .rst_n, .store_i(store), .read_row_i(read_row), .read_col_i(read_col),
        .rdata_i, .pad_i(pad),
        .edge_top_i(edge_top), .edge_bottom_i(edge_bottom),
        .edge_left_i(edge_left), .edge_right_i(edge_right),
        .wr_row_i(wr_row), .wr_col_i(wr_col), .wdata_o
    );

endmodule

// File: tile/pad_tile_buffer.sv
// 6x6 tile store of the padding DMA
// Takes the 4x4 core from read beats, mirrors it into the edge borders
// on the pad pulse and feeds write data by row and column index
`timescale 1ns/1ps

module pad_tile_buffer #(
    parameter int DATA_W = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                store_i,
    input  logic [1:0]                          read_row_i,
    input  logic [1:0]                          read_col_i,
    input  logic [DATA_W-1:0]                   rdata_i,
    input  logic                                pad_i,
    input  logic                                edge_top_i,
    input  logic                                edge_bottom_i,
    input  logic                                edge_left_i,
    input  logic                                edge_right_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  wr_row_i,
    input  logic [pad_dma_pkg::TILE_IDX_W-1:0]  wr_col_i,
    output logic [DATA_W-1:0]                   wdata_o
);
    import pad_dma_pkg::*;

    localparam int LO = TILE_DIM - 1;   // Far border index
    localparam int MR = TILE_DIM - 3;   // Core cell mirrored into the far border

    logic [DATA_W-1:0]     tile [0:TILE_DIM-1][0:TILE_DIM-1];
    logic [TILE_IDX_W-1:0] st_row, st_col;

    // Core sits one cell in from the border
    assign st_row = TILE_IDX_W'(read_row_i) + 1'b1;
    assign st_col = TILE_IDX_W'(read_col_i) + 1'b1;

    always_ff @(posedge clk) begin
        if (rst_n) begin                    // No writes while in reset
            if (store_i)
                tile[st_row][st_col] <= rdata_i;
            if (pad_i) begin
                // Sources are core cells only, so all copies happen at once
                for (int i = 1; i <= BLOCK_DIM; i++) begin
                    if (edge_top_i)    tile[0][i]  <= tile[2][i];
                    if (edge_bottom_i) tile[LO][i] <= tile[MR][i];
                    if (edge_left_i)   tile[i][0]  <= tile[i][2];
                    if (edge_right_i)  tile[i][LO] <= tile[i][MR];
                end
                if (edge_top_i && edge_left_i)     tile[0][0]   <= tile[2][2];
                if (edge_top_i && edge_right_i)    tile[0][LO]  <= tile[2][MR];
                if (edge_bottom_i && edge_left_i)  tile[LO][0]  <= tile[MR][2];
                if (edge_bottom_i && edge_right_i) tile[LO][LO] <= tile[MR][MR];
            end
        end
    end

    assign wdata_o = tile[wr_row_i][wr_col_i];

endmodule
